// ==== filelist.f ====
source/mipsIsaPkg.sv
source/ctrlPkg.sv
source/instrDecoder.sv
source/controlSequencer.sv
source/controlOutputs.sv
source/multicycleControl.sv
tb/multicycleControlTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
if ! verilator --binary --timing -f filelist.f --top-module multicycleControlTb; then
    echo "Verilator build failed"
    exit 1
fi
if ! simOut=$(./obj_dir/VmulticycleControlTb); then
    printf '%s\n' "$simOut"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$simOut"
if printf '%s\n' "$simOut" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== source/controlOutputs.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlOutputs
(
    input  wire ctrlPkg::ctrlStateT state,
    input  wire ctrlPkg::instrInfoT info,
    output ctrlPkg::ctrlEnablesT    enables,
    output ctrlPkg::ctrlSelectsT    selects,
    output ctrlPkg::aluOpT          aluOp,
    output ctrlPkg::memWidthT       memWidth
);

    always_comb
    begin
        enables             = '0;
        selects.aluSrcA     = ctrlPkg::srcARegA;
        selects.aluSrcB     = ctrlPkg::srcBRegB;
        selects.regDst      = ctrlPkg::dstRt;
        selects.memToReg    = ctrlPkg::wbMemData;
        selects.pcSrc       = ctrlPkg::pcPlus4;
        aluOp               = ctrlPkg::aluAdd;
        memWidth.readWidth  = ctrlPkg::rdWord;
        memWidth.writeWidth = ctrlPkg::wrWord;

        case (state)
            ctrlPkg::sFetch:
            begin
                enables.pcWrite = 1'b1;
                enables.irWrite = 1'b1;
                selects.aluSrcA = ctrlPkg::srcAPc;     // PC + 4
                selects.aluSrcB = ctrlPkg::srcBFour;
            end
            ctrlPkg::sDecode:
            begin
                selects.aluSrcA = ctrlPkg::srcAPc;     // Branch target ahead of time
                selects.aluSrcB = ctrlPkg::srcBBranchOff;
            end
            ctrlPkg::sMemAddr:
            begin
                selects.aluSrcB = ctrlPkg::srcBSignImm;   // rs + offset
            end
            ctrlPkg::sMemLoad:
            begin
                enables.memRead    = 1'b1;
                memWidth.readWidth = info.readWidth;
            end
            ctrlPkg::sMemStore:
            begin
                enables.memWrite    = 1'b1;
                memWidth.writeWidth = info.writeWidth;
            end
            ctrlPkg::sExecute:
            begin
                aluOp = info.aluOp;
                // An I-type result goes to rt and its second operand is the immediate
                if (info.regDst == ctrlPkg::dstRt)
                begin
                    selects.aluSrcB = ctrlPkg::srcBSignImm;
                end
                if (info.shamtSrc)
                begin
                    selects.aluSrcA = ctrlPkg::srcAShamt;
                end
            end
            ctrlPkg::sAluWriteBack:
            begin
                enables.regWrite = 1'b1;
                selects.memToReg = ctrlPkg::wbAluOut;
                selects.regDst   = info.regDst;
            end
            ctrlPkg::sLoadWriteBack:
            begin
                enables.regWrite = 1'b1;               // Memory data into rt
            end
            ctrlPkg::sBranch:
            begin
                enables.pcWriteCond = 1'b1;
                selects.pcSrc       = ctrlPkg::pcBranch;
                aluOp               = info.aluOp;
            end
            ctrlPkg::sJump:
            begin
                enables.pcWrite = 1'b1;
                if (info.instrClass == ctrlPkg::clsJump)
                begin
                    selects.pcSrc = ctrlPkg::pcJump;
                end
                else
                begin
                    selects.pcSrc = ctrlPkg::pcRegA;
                end
                if (info.link)
                begin
                    enables.regWrite = 1'b1;           // PC + 4 into r31
                    selects.regDst   = ctrlPkg::dstRa;
                    selects.memToReg = ctrlPkg::wbPcPlus4;
                end
            end
            default:
            begin
                // sInitial keeps the inactive word
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/controlSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlSequencer
(
    input  wire                clk,
    input  wire                arstN,
    input  wire ctrlPkg::instrInfoT info,
    output ctrlPkg::ctrlStateT state
);

    ctrlPkg::ctrlStateT nextState;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= ctrlPkg::sInitial;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        nextState = ctrlPkg::sInitial;
        case (state)
            ctrlPkg::sInitial: nextState = ctrlPkg::sFetch;
            ctrlPkg::sFetch:   nextState = ctrlPkg::sDecode;
            ctrlPkg::sDecode:
            begin
                case (info.instrClass)
                    ctrlPkg::clsAluReg, ctrlPkg::clsAluImm: nextState = ctrlPkg::sExecute;
                    ctrlPkg::clsLoad, ctrlPkg::clsStore:    nextState = ctrlPkg::sMemAddr;
                    ctrlPkg::clsBranch:                     nextState = ctrlPkg::sBranch;
                    ctrlPkg::clsJump, ctrlPkg::clsJumpReg:  nextState = ctrlPkg::sJump;
                    default:                                nextState = ctrlPkg::sInitial;
                endcase
            end
            ctrlPkg::sMemAddr:
            begin
                if (info.instrClass == ctrlPkg::clsLoad)
                begin
                    nextState = ctrlPkg::sMemLoad;
                end
                else
                begin
                    nextState = ctrlPkg::sMemStore;
                end
            end
            ctrlPkg::sMemLoad: nextState = ctrlPkg::sLoadWriteBack;
            ctrlPkg::sExecute: nextState = ctrlPkg::sAluWriteBack;
            ctrlPkg::sMemStore, ctrlPkg::sAluWriteBack, ctrlPkg::sLoadWriteBack,
            ctrlPkg::sBranch, ctrlPkg::sJump:
                nextState = ctrlPkg::sFetch;   // Instruction done
            default:
                nextState = ctrlPkg::sInitial;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef enum logic [3:0]
    {
        sInitial       = 4'd0,
        sFetch         = 4'd1,
        sDecode        = 4'd2,
        sMemAddr       = 4'd3,
        sMemLoad       = 4'd4,
        sMemStore      = 4'd5,
        sExecute       = 4'd6,
        sAluWriteBack  = 4'd7,
        sLoadWriteBack = 4'd8,
        sBranch        = 4'd9,
        sJump          = 4'd10
    } ctrlStateT;

    typedef enum logic [2:0]
    {
        clsAluReg, clsAluImm, clsLoad, clsStore,
        clsBranch, clsJump, clsJumpReg, clsIllegal
    } instrClassT;

    typedef enum logic [4:0]
    {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluAndi, aluOri, aluXori,   // Zero-extended immediate
        aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui,
        aluBne, aluBgtz, aluBlez    // Branch compares
    } aluOpT;

    typedef enum logic [1:0] {srcARegA, srcAPc, srcAShamt} aluSrcAT;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBSignImm, srcBBranchOff} aluSrcBT;
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
    typedef enum logic [1:0] {wbMemData, wbAluOut, wbPcPlus4} memToRegT;
    typedef enum logic [1:0] {pcPlus4, pcBranch, pcJump, pcRegA} pcSrcT;

    typedef enum logic [2:0] {rdWord, rdHalf, rdHalfU, rdByte, rdByteU} memReadWidthT;
    typedef enum logic [1:0] {wrWord, wrHalf, wrByte} memWriteWidthT;

    typedef struct packed
    {
        instrClassT    instrClass;
        aluOpT         aluOp;       // Execute or branch operation
        logic          shamtSrc;    // Shift amount from Instr[10:6]
        regDstT        regDst;
        logic          link;        // jal and jalr
        memReadWidthT  readWidth;
        memWriteWidthT writeWidth;
    } instrInfoT;

    typedef struct packed
    {
        logic pcWrite;
        logic pcWriteCond;
        logic irWrite;
        logic regWrite;
        logic memRead;
        logic memWrite;
    } ctrlEnablesT;

    typedef struct packed
    {
        aluSrcAT  aluSrcA;
        aluSrcBT  aluSrcB;
        regDstT   regDst;
        memToRegT memToReg;
        pcSrcT    pcSrc;
    } ctrlSelectsT;

    typedef struct packed
    {
        memReadWidthT  readWidth;
        memWriteWidthT writeWidth;
    } memWidthT;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
(
    input  wire mipsIsaPkg::opcodeT opcode,
    input  wire mipsIsaPkg::functT  funct,
    output ctrlPkg::instrInfoT      info
);

    always_comb
    begin
        info.instrClass = ctrlPkg::clsIllegal;
        info.aluOp      = ctrlPkg::aluAdd;
        info.shamtSrc   = 1'b0;
        info.regDst     = ctrlPkg::dstRt;
        info.link       = 1'b0;
        info.readWidth  = ctrlPkg::rdWord;
        info.writeWidth = ctrlPkg::wrWord;

        case (opcode)
            mipsIsaPkg::opRtype:
            begin
                info.instrClass = ctrlPkg::clsAluReg;
                info.regDst     = ctrlPkg::dstRd;
                case (funct)
                    mipsIsaPkg::functAdd, mipsIsaPkg::functAddu: info.aluOp = ctrlPkg::aluAdd;
                    mipsIsaPkg::functSub, mipsIsaPkg::functSubu: info.aluOp = ctrlPkg::aluSub;
                    mipsIsaPkg::functAnd:  info.aluOp = ctrlPkg::aluAnd;
                    mipsIsaPkg::functOr:   info.aluOp = ctrlPkg::aluOr;
                    mipsIsaPkg::functXor:  info.aluOp = ctrlPkg::aluXor;
                    mipsIsaPkg::functNor:  info.aluOp = ctrlPkg::aluNor;
                    mipsIsaPkg::functSlt:  info.aluOp = ctrlPkg::aluSlt;
                    mipsIsaPkg::functSltu: info.aluOp = ctrlPkg::aluSltu;
                    mipsIsaPkg::functSll, mipsIsaPkg::functSllv: info.aluOp = ctrlPkg::aluSll;
                    mipsIsaPkg::functSrl, mipsIsaPkg::functSrlv: info.aluOp = ctrlPkg::aluSrl;
                    mipsIsaPkg::functSra, mipsIsaPkg::functSrav: info.aluOp = ctrlPkg::aluSra;
                    mipsIsaPkg::functJr:   info.instrClass = ctrlPkg::clsJumpReg;
                    mipsIsaPkg::functJalr:
                    begin
                        info.instrClass = ctrlPkg::clsJumpReg;
                        info.link       = 1'b1;
                        info.regDst     = ctrlPkg::dstRa;
                    end
                    default: info.instrClass = ctrlPkg::clsIllegal;
                endcase
                // Only the fixed shifts take shamt
                info.shamtSrc = funct inside {mipsIsaPkg::functSll, mipsIsaPkg::functSrl,
                                              mipsIsaPkg::functSra};
            end
            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu, mipsIsaPkg::opAndi,
            mipsIsaPkg::opOri, mipsIsaPkg::opXori, mipsIsaPkg::opSlti,
            mipsIsaPkg::opSltiu, mipsIsaPkg::opLui:
                info.instrClass = ctrlPkg::clsAluImm;
            mipsIsaPkg::opLw, mipsIsaPkg::opLh, mipsIsaPkg::opLhu,
            mipsIsaPkg::opLb, mipsIsaPkg::opLbu:
                info.instrClass = ctrlPkg::clsLoad;
            mipsIsaPkg::opSw, mipsIsaPkg::opSh, mipsIsaPkg::opSb:
                info.instrClass = ctrlPkg::clsStore;
            mipsIsaPkg::opBeq, mipsIsaPkg::opBne, mipsIsaPkg::opBgtz, mipsIsaPkg::opBlez:
                info.instrClass = ctrlPkg::clsBranch;
            mipsIsaPkg::opJ:
                info.instrClass = ctrlPkg::clsJump;
            mipsIsaPkg::opJal:
            begin
                info.instrClass = ctrlPkg::clsJump;
                info.link       = 1'b1;   // Return address to r31
                info.regDst     = ctrlPkg::dstRa;
            end
            default:
                info.instrClass = ctrlPkg::clsIllegal;
        endcase

        // Per-opcode operation and access width
        case (opcode)
            mipsIsaPkg::opAddi, mipsIsaPkg::opAddiu: info.aluOp = ctrlPkg::aluAdd;
            mipsIsaPkg::opAndi:  info.aluOp = ctrlPkg::aluAndi;
            mipsIsaPkg::opOri:   info.aluOp = ctrlPkg::aluOri;
            mipsIsaPkg::opXori:  info.aluOp = ctrlPkg::aluXori;
            mipsIsaPkg::opSlti:  info.aluOp = ctrlPkg::aluSlt;
            mipsIsaPkg::opSltiu: info.aluOp = ctrlPkg::aluSltu;
            mipsIsaPkg::opLui:   info.aluOp = ctrlPkg::aluLui;
            mipsIsaPkg::opBeq:   info.aluOp = ctrlPkg::aluSub;   // Zero flag on equal
            mipsIsaPkg::opBne:   info.aluOp = ctrlPkg::aluBne;
            mipsIsaPkg::opBgtz:  info.aluOp = ctrlPkg::aluBgtz;
            mipsIsaPkg::opBlez:  info.aluOp = ctrlPkg::aluBlez;
            mipsIsaPkg::opLh:    info.readWidth = ctrlPkg::rdHalf;
            mipsIsaPkg::opLhu:   info.readWidth = ctrlPkg::rdHalfU;
            mipsIsaPkg::opLb:    info.readWidth = ctrlPkg::rdByte;
            mipsIsaPkg::opLbu:   info.readWidth = ctrlPkg::rdByteU;
            mipsIsaPkg::opSh:    info.writeWidth = ctrlPkg::wrHalf;
            mipsIsaPkg::opSb:    info.writeWidth = ctrlPkg::wrByte;
            default:
            begin
                // R-type and word accesses keep the values set above
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

    typedef logic [5:0] opcodeT;   // Instr[31:26]
    typedef logic [5:0] functT;    // Instr[5:0]

    localparam opcodeT opRtype = 6'h00;
    localparam opcodeT opJ     = 6'h02;
    localparam opcodeT opJal   = 6'h03;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opBne   = 6'h05;
    localparam opcodeT opBlez  = 6'h06;
    localparam opcodeT opBgtz  = 6'h07;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opSlti  = 6'h0a;
    localparam opcodeT opSltiu = 6'h0b;
    localparam opcodeT opAndi  = 6'h0c;
    localparam opcodeT opOri   = 6'h0d;
    localparam opcodeT opXori  = 6'h0e;
    localparam opcodeT opLui   = 6'h0f;
    localparam opcodeT opLb    = 6'h20;
    localparam opcodeT opLh    = 6'h21;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opLbu   = 6'h24;
    localparam opcodeT opLhu   = 6'h25;
    localparam opcodeT opSb    = 6'h28;
    localparam opcodeT opSh    = 6'h29;
    localparam opcodeT opSw    = 6'h2b;

    localparam functT functSll  = 6'h00;   // Shift by shamt
    localparam functT functSrl  = 6'h02;
    localparam functT functSra  = 6'h03;
    localparam functT functSllv = 6'h04;   // Shift by rs
    localparam functT functSrlv = 6'h06;
    localparam functT functSrav = 6'h07;
    localparam functT functJr   = 6'h08;
    localparam functT functJalr = 6'h09;
    localparam functT functAdd  = 6'h20;
    localparam functT functAddu = 6'h21;
    localparam functT functSub  = 6'h22;
    localparam functT functSubu = 6'h23;
    localparam functT functAnd  = 6'h24;
    localparam functT functOr   = 6'h25;
    localparam functT functXor  = 6'h26;
    localparam functT functNor  = 6'h27;
    localparam functT functSlt  = 6'h2a;
    localparam functT functSltu = 6'h2b;

endpackage

`default_nettype wire

// ==== source/multicycleControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module multicycleControl
(
    input  wire                     clk,
    input  wire                     arstN,
    input  wire mipsIsaPkg::opcodeT opcode,
    input  wire mipsIsaPkg::functT  funct,
    output ctrlPkg::ctrlEnablesT    enables,
    output ctrlPkg::ctrlSelectsT    selects,
    output ctrlPkg::aluOpT          aluOp,
    output ctrlPkg::memWidthT       memWidth
);

    ctrlPkg::instrInfoT info;
    ctrlPkg::ctrlStateT state;

    instrDecoder decoder
    (
        .opcode   (opcode),
        .funct    (funct),
        .info     (info)
    );

    controlSequencer sequencer
    (
        .clk      (clk),
        .arstN    (arstN),
        .info     (info),
        .state    (state)
    );

    controlOutputs outputStage
    (
        .state    (state),
        .info     (info),
        .enables  (enables),
        .selects  (selects),
        .aluOp    (aluOp),
        .memWidth (memWidth)
    );

endmodule

`default_nettype wire

// ==== tb/controlGolden.txt ====
// opcode funct enables selects aluOp memWidth in hex
// One line per clock cycle from the inactive cycle after reset
00 20 00 000 00 00
00 20 28 140 00 00
00 20 00 1c0 00 00
00 20 00 000 00 00
00 20 04 014 00 00
00 00 28 140 00 00
00 00 00 1c0 00 00
00 00 00 200 0b 00
00 00 04 014 00 00
0d 00 28 140 00 00
0d 00 00 1c0 00 00
0d 00 00 080 07 00
0d 00 04 004 00 00
23 00 28 140 00 00
23 00 00 1c0 00 00
23 00 00 080 00 00
23 00 02 000 00 00
23 00 04 000 00 00
21 00 28 140 00 00
21 00 00 1c0 00 00
21 00 00 080 00 00
21 00 02 000 00 04
21 00 04 000 00 00
25 00 28 140 00 00
25 00 00 1c0 00 00
25 00 00 080 00 00
25 00 02 000 00 08
25 00 04 000 00 00
20 00 28 140 00 00
20 00 00 1c0 00 00
20 00 00 080 00 00
20 00 02 000 00 0c
20 00 04 000 00 00
24 00 28 140 00 00
24 00 00 1c0 00 00
24 00 00 080 00 00
24 00 02 000 00 10
24 00 04 000 00 00
2b 00 28 140 00 00
2b 00 00 1c0 00 00
2b 00 00 080 00 00
2b 00 01 000 00 00
29 00 28 140 00 00
29 00 00 1c0 00 00
29 00 00 080 00 00
29 00 01 000 00 01
28 00 28 140 00 00
28 00 00 1c0 00 00
28 00 00 080 00 00
28 00 01 000 00 02
04 00 28 140 00 00
04 00 00 1c0 00 00
04 00 10 001 01 00
05 00 28 140 00 00
05 00 00 1c0 00 00
05 00 10 001 0f 00
07 00 28 140 00 00
07 00 00 1c0 00 00
07 00 10 001 10 00
06 00 28 140 00 00
06 00 00 1c0 00 00
06 00 10 001 11 00
02 00 28 140 00 00
02 00 00 1c0 00 00
02 00 20 002 00 00
03 00 28 140 00 00
03 00 00 1c0 00 00
03 00 24 02a 00 00
00 08 28 140 00 00
00 08 00 1c0 00 00
00 08 20 003 00 00
00 09 28 140 00 00
00 09 00 1c0 00 00
00 09 24 02b 00 00
3f 00 28 140 00 00
3f 00 00 1c0 00 00
3f 00 00 000 00 00
00 20 28 140 00 00

// ==== tb/multicycleControlTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module multicycleControlTb;

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 4;
    localparam int edgeLimit   = 4;     // Clock changes allowed per wait
    localparam int lineWords   = 6;     // Hex words per golden line
    localparam int maxLines    = 100;

    logic                 clk;
    logic                 arstN;
    mipsIsaPkg::opcodeT   opcode;
    mipsIsaPkg::functT    funct;
    ctrlPkg::ctrlEnablesT enables;
    ctrlPkg::ctrlSelectsT selects;
    ctrlPkg::aluOpT       aluOp;
    ctrlPkg::memWidthT    memWidth;
    logic [15:0]          goldenMem [lineWords * maxLines];
    logic [5:0]           randFunct;   // Driven as funct outside R-type
    int                   lineCount;
    int                   mismatches;
    int                   runErrors;

    multicycleControl DUT (.*);

    always #(clkPeriod / 2) clk = ~clk;

    task automatic waitFallingEdge;
        int changes;
        changes = 0;
        while (changes == 0 || (clk !== 1'b0 && changes < edgeLimit))
        begin
            @(clk);
            changes++;
        end
        if (clk !== 1'b0)
        begin
            $display("Timeout at %0t waiting for a falling clock edge", $time);
            runErrors++;
        end
    endtask

    task automatic checkField(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    initial
    begin
        clk        = 1'b0;
        arstN      = 1'b0;
        opcode     = '0;
        funct      = '0;
        lineCount  = 0;
        mismatches = 0;
        runErrors  = 0;
        randFunct  = 6'($urandom(32'h62ae_ab7f));
        goldenMem  = '{default: 16'hffff};   // Marks lines past the end of the file
        $readmemh("tb/controlGolden.txt", goldenMem);
        while (lineCount < maxLines && goldenMem[lineCount * lineWords] != 16'hffff)
        begin
            lineCount++;
        end
        if (lineCount == 0)
        begin
            $display("No stimulus lines could be read from tb/controlGolden.txt");
            runErrors++;
        end
        for (int cycle = 1; cycle < resetCycles; cycle++)
        begin
            waitFallingEdge();
        end
        for (int line = 0; line < lineCount; line++)
        begin
            int base;
            base = line * lineWords;
            waitFallingEdge();
            arstN = 1'b1;                    // Released at the fourth falling edge
            if (goldenMem[base + 2][3])
            begin
                randFunct = 6'($urandom());  // irWrite starts a new instruction
            end
            opcode = 6'(goldenMem[base]);
            funct  = (opcode == mipsIsaPkg::opRtype) ? 6'(goldenMem[base + 1]) : randFunct;
            #(clkPeriod / 4);
            checkField("enables", goldenMem[base + 2], 16'(enables));
            checkField("selects", goldenMem[base + 3], 16'(selects));
            checkField("aluOp", goldenMem[base + 4], 16'(aluOp));
            checkField("memWidth", goldenMem[base + 5], 16'(memWidth));
        end
        $display("Errors %0d mismatches and %0d other failures", mismatches, runErrors);
        if (mismatches == 0 && runErrors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
